/* src/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // 800x600 at 40 MHz, 1056x628 total.
    localparam int h_active = 800;
    localparam int h_front  = 40;
    localparam int h_sync   = 128;
    localparam int h_total  = 1056;

    localparam int v_active = 600;
    localparam int v_front  = 1;
    localparam int v_sync   = 4;
    localparam int v_total  = 628;

    localparam int spr_width  = 8;
    localparam int spr_height = 4;
    localparam int spr_xw     = $clog2(spr_width);
    localparam int spr_yw     = $clog2(spr_height);
    localparam int spr_words  = spr_width * spr_height;

    localparam logic [11:0] transp_key = 12'h02F; // Never painted.

    localparam int n_layers      = 4;
    localparam int layer_aw      = $clog2(n_layers);
    localparam int layer_latency = 3;

    // Offsets inside each 16-byte layer window.
    localparam logic [3:0] reg_pos_x = 4'h0;
    localparam logic [3:0] reg_pos_y = 4'h4;
    localparam logic [3:0] reg_ctrl  = 4'h8;
    localparam logic [7:0] reg_bg    = 8'h40;

    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_state_t;

endpackage

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  logic            clk,
    input  logic            rst,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk
);
    import vga_pkg::*;

    coord_t h_nxt;
    coord_t v_nxt;

    // Decodes are taken from the next count so they line up with the counters.
    always_comb begin
        h_nxt = hcount + 11'd1;
        v_nxt = vcount;
        if (hcount == coord_t'(h_total - 1)) begin
            h_nxt = '0;
            v_nxt = (vcount == coord_t'(v_total - 1)) ? '0 : vcount + 11'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= h_nxt;
            vcount <= v_nxt;
            hblnk  <= h_nxt >= coord_t'(h_active);
            vblnk  <= v_nxt >= coord_t'(v_active);
            hsync  <= (h_nxt >= coord_t'(h_active + h_front)) &&
                      (h_nxt <  coord_t'(h_active + h_front + h_sync));
            vsync  <= (v_nxt >= coord_t'(v_active + v_front)) &&
                      (v_nxt <  coord_t'(v_active + v_front + v_sync));
        end
    end

endmodule

`default_nettype wire

/* src/sprite_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [7:0]                           paddr,
    input  logic [31:0]                          pwdata,
    input  vga_pkg::coord_t                      hcount,
    input  vga_pkg::coord_t                      vcount,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic [vga_pkg::n_layers*11-1:0]      layer_x,
    output logic [vga_pkg::n_layers*11-1:0]      layer_y,
    output logic [vga_pkg::n_layers-1:0]         layer_en,
    output logic [vga_pkg::n_layers-1:0]         layer_flip,
    output vga_pkg::rgb_t                        bg_rgb
);
    import vga_pkg::*;

    apb_state_t          state;
    logic                access_cyc;
    logic                layer_ok;
    logic                bg_sel;
    logic                mapped;
    logic [layer_aw-1:0] idx;
    logic [3:0]          offs;

    coord_t              pos_x_r [n_layers];
    coord_t              pos_y_r [n_layers];
    logic [n_layers-1:0] en_r;
    logic [n_layers-1:0] flip_r;
    rgb_t                bg_r;

    // State holds the bus phase of the previous cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else if (!psel) begin
            state <= idle;
        end else begin
            state <= penable ? access : setup;
        end
    end

    assign access_cyc = psel && penable && (state == setup);

    assign idx      = paddr[4 +: layer_aw];
    assign offs     = paddr[3:0];
    assign bg_sel   = (paddr == reg_bg);
    assign layer_ok = (paddr[7:4] < 4'(n_layers)) &&
                      (offs == reg_pos_x || offs == reg_pos_y || offs == reg_ctrl);
    assign mapped   = layer_ok || bg_sel;

    assign pready  = 1'b1;
    assign pslverr = access_cyc && !mapped;

    always_comb begin
        prdata = '0;
        if (bg_sel) begin
            prdata[11:0] = bg_r;
        end else if (layer_ok) begin
            case (offs)
                reg_pos_x: prdata[10:0] = pos_x_r[idx];
                reg_pos_y: prdata[10:0] = pos_y_r[idx];
                default:   prdata[1:0]  = {flip_r[idx], en_r[idx]};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < n_layers; k++) begin
                pos_x_r[k] <= '0;
                pos_y_r[k] <= '0;
            end
            en_r   <= '0;
            flip_r <= '0;
            bg_r   <= '0;
        end else if (access_cyc && pwrite && mapped) begin
            if (bg_sel) begin
                bg_r <= pwdata[11:0];
            end else begin
                case (offs)
                    reg_pos_x: pos_x_r[idx] <= pwdata[10:0];
                    reg_pos_y: pos_y_r[idx] <= pwdata[10:0];
                    default: begin
                        en_r[idx]   <= pwdata[0];
                        flip_r[idx] <= pwdata[1];
                    end
                endcase
            end
        end
    end

    // Layers see new settings only from the top-left pixel onward.
    always_ff @(posedge clk) begin
        if (rst) begin
            layer_x    <= '0;
            layer_y    <= '0;
            layer_en   <= '0;
            layer_flip <= '0;
            bg_rgb     <= '0;
        end else if (hcount == '0 && vcount == '0) begin
            for (int k = 0; k < n_layers; k++) begin
                layer_x[k*11 +: 11] <= pos_x_r[k];
                layer_y[k*11 +: 11] <= pos_y_r[k];
            end
            layer_en   <= en_r;
            layer_flip <= flip_r;
            bg_rgb     <= bg_r;
        end
    end

    apb_enable_after_setup: assert property (
        @(posedge clk) disable iff (rst) penable |-> psel && state == setup
    );

endmodule

`default_nettype wire

/* src/sprite_layer.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_layer (
    input  logic            clk,
    input  logic            rst,
    input  vga_pkg::coord_t pos_x,
    input  vga_pkg::coord_t pos_y,
    input  logic            enable,
    input  logic            flip,
    input  vga_pkg::coord_t hcount_in,
    input  vga_pkg::coord_t vcount_in,
    input  logic            hsync_in,
    input  logic            vsync_in,
    input  logic            hblnk_in,
    input  logic            vblnk_in,
    input  vga_pkg::rgb_t   rgb_in,
    input  logic [1:0]      hit_in,
    output vga_pkg::coord_t hcount_out,
    output vga_pkg::coord_t vcount_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            hblnk_out,
    output logic            vblnk_out,
    output vga_pkg::rgb_t   rgb_out,
    output logic [1:0]      hit_out
);
    import vga_pkg::*;

    rgb_t rom [spr_words];

    initial $readmemh("src/sprite.mem", rom);

    logic                    in_box;
    logic                    paint;
    coord_t                  dx;
    coord_t                  dy;
    logic [spr_xw-1:0]       col;
    logic [spr_xw+spr_yw-1:0] rom_addr;
    rgb_t                    pixel;
    rgb_t                    rgb_nxt;
    logic [1:0]              hit_nxt;

    coord_t     hc_q    [layer_latency];
    coord_t     vc_q    [layer_latency];
    logic       hsync_q [layer_latency];
    logic       vsync_q [layer_latency];
    logic       hblnk_q [layer_latency];
    logic       vblnk_q [layer_latency];
    rgb_t       rgb_q   [layer_latency];
    logic [1:0] hit_q   [layer_latency];

    // Window is compared one bit wider so a sprite at the right edge never wraps.
    assign in_box = enable && !hblnk_in && !vblnk_in &&
                    (hcount_in >= pos_x) &&
                    ({1'b0, hcount_in} < {1'b0, pos_x} + 12'(spr_width)) &&
                    (vcount_in >= pos_y) &&
                    ({1'b0, vcount_in} < {1'b0, pos_y} + 12'(spr_height));

    assign dx       = hcount_in - pos_x;
    assign dy       = vcount_in - pos_y;
    assign col      = flip ? ~dx[spr_xw-1:0] : dx[spr_xw-1:0]; // Mirror is 7 minus column.
    assign rom_addr = {dy[spr_yw-1:0], col};
    assign pixel    = rom[rom_addr];
    assign paint    = in_box && (pixel != transp_key);

    assign rgb_nxt = paint ? pixel : rgb_in;
    assign hit_nxt = (paint && hit_in != 2'd3) ? hit_in + 2'd1 : hit_in;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < layer_latency; i++) begin
                hc_q[i]    <= '0;
                vc_q[i]    <= '0;
                hsync_q[i] <= 1'b0;
                vsync_q[i] <= 1'b0;
                hblnk_q[i] <= 1'b0;
                vblnk_q[i] <= 1'b0;
                rgb_q[i]   <= '0;
                hit_q[i]   <= '0;
            end
        end else begin
            hc_q[0]    <= hcount_in;
            vc_q[0]    <= vcount_in;
            hsync_q[0] <= hsync_in;
            vsync_q[0] <= vsync_in;
            hblnk_q[0] <= hblnk_in;
            vblnk_q[0] <= vblnk_in;
            rgb_q[0]   <= rgb_nxt;
            hit_q[0]   <= hit_nxt;
            for (int i = 1; i < layer_latency; i++) begin
                hc_q[i]    <= hc_q[i-1];
                vc_q[i]    <= vc_q[i-1];
                hsync_q[i] <= hsync_q[i-1];
                vsync_q[i] <= vsync_q[i-1];
                hblnk_q[i] <= hblnk_q[i-1];
                vblnk_q[i] <= vblnk_q[i-1];
                rgb_q[i]   <= rgb_q[i-1];
                hit_q[i]   <= hit_q[i-1];
            end
        end
    end

    assign hcount_out = hc_q[layer_latency-1];
    assign vcount_out = vc_q[layer_latency-1];
    assign hsync_out  = hsync_q[layer_latency-1];
    assign vsync_out  = vsync_q[layer_latency-1];
    assign hblnk_out  = hblnk_q[layer_latency-1];
    assign vblnk_out  = vblnk_q[layer_latency-1];
    assign rgb_out    = rgb_q[layer_latency-1];
    assign hit_out    = hit_q[layer_latency-1];

    // A single layer adds at most one hit to the pixel it delays.
    hit_step_bound: assert property (
        @(posedge clk) disable iff (rst)
        3'(hit_out) <= 3'($past(hit_in, layer_latency)) + 3'd1
    );

endmodule

`default_nettype wire

/* src/pixel_out.sv */
`timescale 1ns/1ns
`default_nettype none

module pixel_out (
    input  logic            clk,
    input  logic            rst,
    input  vga_pkg::coord_t hcount_in,
    input  vga_pkg::coord_t vcount_in,
    input  logic            hsync_in,
    input  logic            vsync_in,
    input  logic            hblnk_in,
    input  logic            vblnk_in,
    input  vga_pkg::rgb_t   rgb_in,
    input  logic [1:0]      hit_in,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb,
    output logic            frame_done,
    output logic            frame_collision
);
    import vga_pkg::*;

    logic active;
    logic vblnk_rise;
    logic sticky;

    assign active     = !hblnk_in && !vblnk_in;
    assign vblnk_rise = vblnk_in && !vblnk; // The vblnk output is the previous input.

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount          <= '0;
            vcount          <= '0;
            hsync           <= 1'b0;
            vsync           <= 1'b0;
            hblnk           <= 1'b0;
            vblnk           <= 1'b0;
            rgb             <= '0;
            frame_done      <= 1'b0;
            frame_collision <= 1'b0;
            sticky          <= 1'b0;
        end else begin
            hcount     <= hcount_in;
            vcount     <= vcount_in;
            hsync      <= hsync_in;
            vsync      <= vsync_in;
            hblnk      <= hblnk_in;
            vblnk      <= vblnk_in;
            rgb        <= active ? rgb_in : rgb_t'(0);
            frame_done <= vblnk_rise;
            if (vblnk_rise) begin
                frame_collision <= sticky;
                sticky          <= 1'b0;
            end else if (active && hit_in >= 2'd2) begin
                sticky <= 1'b1; // Two opaque sprites share this pixel.
            end
        end
    end

endmodule

`default_nettype wire

/* src/sprite_overlay_top.sv */
`timescale 1ns/1ns
`default_nettype none

module sprite_overlay_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [7:0]      paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    output vga_pkg::coord_t hcount,
    output vga_pkg::coord_t vcount,
    output logic            hsync,
    output logic            vsync,
    output logic            hblnk,
    output logic            vblnk,
    output vga_pkg::rgb_t   rgb,
    output logic            frame_done,
    output logic            frame_collision
);
    import vga_pkg::*;

    // Element 0 is the raw raster, element k+1 leaves layer k.
    coord_t     hc    [n_layers+1];
    coord_t     vc    [n_layers+1];
    logic       hs    [n_layers+1];
    logic       vs    [n_layers+1];
    logic       hb    [n_layers+1];
    logic       vb    [n_layers+1];
    rgb_t       rgb_c [n_layers+1];
    logic [1:0] hit_c [n_layers+1];

    logic [n_layers*11-1:0] layer_x;
    logic [n_layers*11-1:0] layer_y;
    logic [n_layers-1:0]    layer_en;
    logic [n_layers-1:0]    layer_flip;
    rgb_t                   bg_rgb;

    vga_timing u_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (hc[0]),
        .vcount (vc[0]),
        .hsync  (hs[0]),
        .vsync  (vs[0]),
        .hblnk  (hb[0]),
        .vblnk  (vb[0])
    );

    sprite_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .hcount     (hc[0]),
        .vcount     (vc[0]),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .layer_x    (layer_x),
        .layer_y    (layer_y),
        .layer_en   (layer_en),
        .layer_flip (layer_flip),
        .bg_rgb     (bg_rgb)
    );

    assign rgb_c[0] = bg_rgb;
    assign hit_c[0] = 2'd0;

    for (genvar k = 0; k < n_layers; k++) begin : g_layer
        sprite_layer u_layer (
            .clk        (clk),
            .rst        (rst),
            .pos_x      (layer_x[k*11 +: 11]),
            .pos_y      (layer_y[k*11 +: 11]),
            .enable     (layer_en[k]),
            .flip       (layer_flip[k]),
            .hcount_in  (hc[k]),
            .vcount_in  (vc[k]),
            .hsync_in   (hs[k]),
            .vsync_in   (vs[k]),
            .hblnk_in   (hb[k]),
            .vblnk_in   (vb[k]),
            .rgb_in     (rgb_c[k]),
            .hit_in     (hit_c[k]),
            .hcount_out (hc[k+1]),
            .vcount_out (vc[k+1]),
            .hsync_out  (hs[k+1]),
            .vsync_out  (vs[k+1]),
            .hblnk_out  (hb[k+1]),
            .vblnk_out  (vb[k+1]),
            .rgb_out    (rgb_c[k+1]),
            .hit_out    (hit_c[k+1])
        );
    end

    pixel_out u_drain (
        .clk             (clk),
        .rst             (rst),
        .hcount_in       (hc[n_layers]),
        .vcount_in       (vc[n_layers]),
        .hsync_in        (hs[n_layers]),
        .vsync_in        (vs[n_layers]),
        .hblnk_in        (hb[n_layers]),
        .vblnk_in        (vb[n_layers]),
        .rgb_in          (rgb_c[n_layers]),
        .hit_in          (hit_c[n_layers]),
        .hcount          (hcount),
        .vcount          (vcount),
        .hsync           (hsync),
        .vsync           (vsync),
        .hblnk           (hblnk),
        .vblnk           (vblnk),
        .rgb             (rgb),
        .frame_done      (frame_done),
        .frame_collision (frame_collision)
    );

endmodule

`default_nettype wire

/* sim/tb_sprite_overlay.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sprite_overlay;
    import vga_pkg::*;

    localparam int          n_frames       = 6;
    localparam int unsigned timeout_cycles = n_frames * h_total * v_total;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    coord_t      hcount;
    coord_t      vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;
    logic        frame_done;
    logic        frame_collision;

    int          errors = 0;
    int          checks = 0;
    int unsigned cycles = 0;

    sprite_overlay_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .hcount          (hcount),
        .vcount          (vcount),
        .hsync           (hsync),
        .vsync           (vsync),
        .hblnk           (hblnk),
        .vblnk           (vblnk),
        .rgb             (rgb),
        .frame_done      (frame_done),
        .frame_collision (frame_collision)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout: the stimulus did not finish within %0d cycles.", timeout_cycles);
            $display("Closing: %0d checks, %0d errors", checks, errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Sync and blank levels of the 800x600 mode, packed as {hsync, vsync, hblnk, vblnk}.
    function automatic logic [3:0] raster_flags(input int h, input int v);
        logic hb;
        logic vb;
        logic hs;
        logic vs;
        hb = (h >= h_active);
        vb = (v >= v_active);
        hs = (h >= h_active + h_front) && (h < h_active + h_front + h_sync);
        vs = (v >= v_active + v_front) && (v < v_active + v_front + v_sync);
        return {hs, vs, hb, vb};
    endfunction

    // Every output pixel carries the syncs and blanks of its own coordinate.
    always @(negedge clk) begin : raster_monitor
        logic [3:0] flags;
        logic       done_exp;
        if (!rst) begin
            flags    = raster_flags(int'(hcount), int'(vcount));
            done_exp = (hcount == '0) && (vcount == coord_t'(v_active)); // First vblank pixel.
            check_value("hsync", 32'(hsync), 32'(flags[3]));
            check_value("vsync", 32'(vsync), 32'(flags[2]));
            check_value("hblnk", 32'(hblnk), 32'(flags[1]));
            check_value("vblnk", 32'(vblnk), 32'(flags[0]));
            check_value("frame_done", 32'(frame_done), 32'(done_exp));
            if (flags[1] || flags[0]) begin
                check_value("rgb in blanking", 32'(rgb), 32'd0);
            end
        end
    end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #2; // Access phase outputs are settled well before the next rising edge.
        check_value($sformatf("prdata[%0h]", addr), prdata, exp_data);
        check_value($sformatf("pslverr[%0h]", addr), 32'(pslverr), 32'(exp_err));
        check_value("pready", 32'(pready), 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Waits for the next time this coordinate leaves the drain stage.
    task automatic probe_pixel(input int h, input int v, input logic [11:0] exp_rgb);
        @(negedge clk);
        while (!(hcount == coord_t'(h) && vcount == coord_t'(v))) begin
            @(negedge clk);
        end
        check_value($sformatf("rgb at (%0d,%0d)", h, v), 32'(rgb), 32'(exp_rgb));
    endtask

    task automatic frame_check(input logic exp_collision);
        @(negedge clk);
        while (!frame_done) begin
            @(negedge clk);
        end
        check_value("frame_collision", 32'(frame_collision), 32'(exp_collision));
    endtask

    // Returns the next record letter, skipping blanks and comment lines; 0 at end of file.
    task automatic next_record(input int fd, output logic [7:0] kind);
        int   c;
        logic in_comment;
        in_comment = 1'b0;
        kind       = 8'h00;
        c          = $fgetc(fd);
        while (c >= 0 && kind == 8'h00) begin
            if (in_comment) begin
                in_comment = (c[7:0] != 8'h0A);
            end else if (c[7:0] == "#") begin
                in_comment = 1'b1;
            end else if (c[7:0] > " ") begin
                kind = c[7:0];
            end
            if (kind == 8'h00) begin
                c = $fgetc(fd);
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          h;
        int          v;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic        done;
        logic        bad;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fd = $fopen("sim/overlay_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/overlay_stimulus.txt.");
            errors++;
        end else begin
            done = 1'b0;
            while (!done) begin
                bad = 1'b0;
                next_record(fd, kind);
                case (kind)
                    "W": begin
                        n = $fscanf(fd, "%h %h", a, d);
                        if (n == 2) apb_write(a[7:0], d);
                        else bad = 1'b1;
                    end
                    "R": begin
                        n = $fscanf(fd, "%h %h %h", a, d, e);
                        if (n == 3) apb_read(a[7:0], d, e[0]);
                        else bad = 1'b1;
                    end
                    "P": begin
                        n = $fscanf(fd, "%d %d %h", h, v, d);
                        if (n == 3) probe_pixel(h, v, d[11:0]);
                        else bad = 1'b1;
                    end
                    "F": begin
                        n = $fscanf(fd, "%h", e);
                        if (n == 1) frame_check(e[0]);
                        else bad = 1'b1;
                    end
                    "E": done = 1'b1;
                    default: begin
                        $display("Stimulus file has an unknown record or ends without E.");
                        errors++;
                        done = 1'b1;
                    end
                endcase
                if (bad) begin
                    $display("Stimulus record %c is missing fields.", kind);
                    errors++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end

        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/vga_pkg.sv
src/vga_timing.sv
src/sprite_regs.sv
src/sprite_layer.sv
src/pixel_out.sv
src/sprite_overlay_top.sv
sim/tb_sprite_overlay.sv

/* run_sim.sh */
#!/bin/sh
# Build from the project root so the ROM image and stimulus paths resolve.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_sprite_overlay -f compile.f \
    && ./obj_dir/Vtb_sprite_overlay | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

/* src/sprite.mem */
// 8x4 sprite, row-major (row * 8 + column), 12-bit RGB; 02F is transparent.
02F
02F
A10
A11
A12
A13
02F
02F
02F
B21
B22
B23
B24
B25
B26
02F
C30
C31
C32
C33
C34
C35
C36
C37
02F
D41
02F
D43
D44
02F
D46
02F

/* sim/overlay_stimulus.txt */
# Records: W addr data | R addr exp_data exp_slverr | P hcount vcount exp_rgb | F exp_collision | E
# Addresses, data and colours are hex; probe coordinates are decimal.
W 40 5A3
W 00 3FF
W 34 2AB
W 28 2
R 00 3FF 0
R 40 5A3 0
R 34 2AB 0
R 28 2 0
R 0C 0 1
R 44 0 1
R 50 0 1
F 0
# Frame 1 shows only the background.
P 400 610 000
P 10 20 5A3
P 900 20 000
P 400 599 5A3
F 0
W 00 064
W 04 12C
W 08 1
W 10 0C8
W 14 12C
W 18 3
R 18 3 0
# Frame 2: layer 0 at (100,300), layer 1 flipped at (200,300).
P 100 300 5A3
P 102 300 A10
P 105 300 A13
P 108 301 5A3
P 201 301 B26
P 207 302 C30
P 101 303 D41
P 200 303 5A3
P 203 303 D44
F 0
# Frame 3: layer 1 overlaps layer 0 from column 4.
W 10 068
W 18 1
P 104 300 A12
P 105 302 C31
F 1
W 10 0C8
# Frame 4: layer 0 is moved mid-frame and stays put until frame 5.
P 10 100 5A3
W 00 12C
P 102 300 A10
P 302 300 5A3
F 0
P 102 300 5A3
P 302 300 A10
E
